/* Makefile */
TOP := tb_top

RTL := design/core_pkg.sv design/unified_memory.sv design/mem_arbiter.sv \
       design/load_store_port.sv design/fetch_stage.sv design/core_front.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module core_front $(RTL)

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f flist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* design/core_front.sv */
`timescale 1ns/1ps

module core_front #(
    parameter int mem_latency = core_pkg::def_mem_latency,
    parameter int mem_addr_w  = core_pkg::def_mem_addr_w
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // fetch interface
    output logic                           if_valid,
    output logic [core_pkg::xlen-1:0]      if_pc,
    output logic [core_pkg::xlen-1:0]      if_inst,
    output logic [core_pkg::inst_id_w-1:0] if_inst_id,
    input  logic                           if_stall,
    input  logic                           branch_hazard,
    input  logic [core_pkg::xlen-1:0]      branch_target,

    // data interface
    input  logic                           ls_req,
    input  logic                           ls_write,
    input  logic [core_pkg::xlen-1:0]      ls_addr,
    input  logic [core_pkg::xlen-1:0]      ls_wdata,
    output logic                           ls_busy,
    output logic                           ls_done,
    output logic [core_pkg::xlen-1:0]      ls_rdata
);
    import core_pkg::*;

    // fetch requester
    logic            f_start;
    logic            f_ready;
    logic [xlen-1:0] f_addr;
    logic [xlen-1:0] f_rdata;
    logic            f_rdata_valid;

    // data requester
    logic            d_start;
    logic            d_ready;
    logic            d_write;
    logic [xlen-1:0] d_addr;
    logic [xlen-1:0] d_wdata;
    logic [xlen-1:0] d_rdata;
    logic            d_rdata_valid;

    // memory bus
    logic            mem_start;
    logic            mem_write;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] mem_wdata;
    logic            mem_ready;
    logic [xlen-1:0] mem_rdata;
    logic            mem_rdata_valid;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_start       (f_start),
        .mem_addr        (f_addr),
        .mem_ready       (f_ready),
        .mem_rdata       (f_rdata),
        .mem_rdata_valid (f_rdata_valid),
        .if_valid        (if_valid),
        .if_pc           (if_pc),
        .if_inst         (if_inst),
        .if_inst_id      (if_inst_id),
        .if_stall        (if_stall),
        .branch_hazard   (branch_hazard),
        .branch_target   (branch_target)
    );

    load_store_port u_lsp (
        .clk           (clk),
        .rst_n         (rst_n),
        .ls_req        (ls_req),
        .ls_write      (ls_write),
        .ls_addr       (ls_addr),
        .ls_wdata      (ls_wdata),
        .ls_busy       (ls_busy),
        .ls_done       (ls_done),
        .ls_rdata      (ls_rdata),
        .d_start       (d_start),
        .d_write       (d_write),
        .d_addr        (d_addr),
        .d_wdata       (d_wdata),
        .d_ready       (d_ready),
        .d_rdata       (d_rdata),
        .d_rdata_valid (d_rdata_valid)
    );

    mem_arbiter #(
        .mem_latency (mem_latency)
    ) u_arb (
        .clk             (clk),
        .rst_n           (rst_n),
        .f_start         (f_start),
        .f_ready         (f_ready),
        .f_addr          (f_addr),
        .f_rdata         (f_rdata),
        .f_rdata_valid   (f_rdata_valid),
        .d_start         (d_start),
        .d_ready         (d_ready),
        .d_write         (d_write),
        .d_addr          (d_addr),
        .d_wdata         (d_wdata),
        .d_rdata         (d_rdata),
        .d_rdata_valid   (d_rdata_valid),
        .mem_start       (mem_start),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

    unified_memory #(
        .mem_latency (mem_latency),
        .mem_addr_w  (mem_addr_w)
    ) u_mem (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_start       (mem_start),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

endmodule

/* design/core_pkg.sv */
package core_pkg;

    // data and address width
    localparam int xlen = 32;

    // fetch attempt counter width
    localparam int inst_id_w = 64;

    // first fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = '0;

    // byte distance between consecutive instructions
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // read latency of the unified memory, in cycles
    // must be at least 1
    localparam int def_mem_latency = 2;

    // word index width, 8 bits gives 256 words
    localparam int def_mem_addr_w = 8;

endpackage

/* design/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                           clk,
    input  logic                           rst_n,

    // memory side, through the arbiter
    output logic                           mem_start,
    output logic [core_pkg::xlen-1:0]      mem_addr,
    input  logic                           mem_ready,
    input  logic [core_pkg::xlen-1:0]      mem_rdata,
    input  logic                           mem_rdata_valid,

    // toward decode
    output logic                           if_valid,
    output logic [core_pkg::xlen-1:0]      if_pc,
    output logic [core_pkg::xlen-1:0]      if_inst,
    output logic [core_pkg::inst_id_w-1:0] if_inst_id,
    input  logic                           if_stall,
    input  logic                           branch_hazard,
    input  logic [core_pkg::xlen-1:0]      branch_target
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        s_wait_ready,
        s_wait_data,
        s_held
    } state_t;

    state_t               state;
    logic [xlen-1:0]      pc_q;
    logic [inst_id_w-1:0] inst_id_q;
    // set while a pre-redirect fetch is still in flight
    logic                 discard_q;

    logic [xlen-1:0]      saved_pc;
    logic [xlen-1:0]      saved_inst;
    logic [inst_id_w-1:0] saved_id;

    logic                 resp_ok;
    logic                 in_flight;
    logic                 issue;

    // response that belongs to pc_q
    assign resp_ok   = (state == s_wait_data) && mem_rdata_valid && !discard_q;
    // fetch outstanding and not returning this cycle
    assign in_flight = (state == s_wait_data) && !mem_rdata_valid;
    assign issue     = mem_start && mem_ready;

    assign if_valid   = !branch_hazard && (resp_ok || state == s_held);
    assign if_pc      = (state == s_held) ? saved_pc   : pc_q;
    assign if_inst    = (state == s_held) ? saved_inst : mem_rdata;
    assign if_inst_id = (state == s_held) ? saved_id   : inst_id_q;

    always_comb begin
        mem_start = 1'b0;
        mem_addr  = pc_q;
        if (branch_hazard) begin
            // redirect now unless an old fetch still holds the memory
            if (!in_flight) begin
                mem_start = 1'b1;
                mem_addr  = branch_target;
            end
        end else begin
            case (state)
                s_wait_ready: mem_start = 1'b1;
                s_wait_data: begin
                    if (mem_rdata_valid && (discard_q || !if_stall)) begin
                        mem_start = 1'b1;
                        // stale data dropped, pc_q already holds the target
                        mem_addr  = discard_q ? pc_q : pc_q + pc_step;
                    end
                end
                s_held:  mem_start = !if_stall;
                default: mem_start = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= s_wait_ready;
            pc_q      <= reset_pc;
            inst_id_q <= '0;
            discard_q <= 1'b0;
        end else if (branch_hazard) begin
            pc_q      <= branch_target;
            inst_id_q <= inst_id_q + inst_id_w'(1);
            if (in_flight) begin
                discard_q <= 1'b1;
                state     <= s_wait_data;
            end else begin
                discard_q <= 1'b0;
                state     <= issue ? s_wait_data : s_wait_ready;
            end
        end else begin
            case (state)
                s_wait_ready: begin
                    if (issue) state <= s_wait_data;
                end
                s_wait_data: begin
                    if (mem_rdata_valid && discard_q) begin
                        discard_q <= 1'b0;
                        state     <= issue ? s_wait_data : s_wait_ready;
                    end else if (mem_rdata_valid) begin
                        pc_q      <= pc_q + pc_step;
                        inst_id_q <= inst_id_q + inst_id_w'(1);
                        if (if_stall) begin
                            state <= s_held;
                        end else begin
                            state <= issue ? s_wait_data : s_wait_ready;
                        end
                    end
                end
                s_held: begin
                    if (!if_stall) state <= issue ? s_wait_data : s_wait_ready;
                end
                default: state <= s_wait_ready;
            endcase
        end
    end

    // copy of the delivered word for the held state
    always_ff @(posedge clk) begin
        if (resp_ok && !branch_hazard) begin
            saved_pc   <= pc_q;
            saved_inst <= mem_rdata;
            saved_id   <= inst_id_q;
        end
    end

    // a stalled instruction stays put until taken or flushed
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (if_valid && if_stall) |=> branch_hazard ||
            (if_valid && $stable(if_pc) && $stable(if_inst) && $stable(if_inst_id))
    ) else $error("fetch output changed during a stall");

endmodule

/* design/load_store_port.sv */
`timescale 1ns/1ps

module load_store_port (
    input  logic                      clk,
    input  logic                      rst_n,

    // external side
    input  logic                      ls_req,
    input  logic                      ls_write,
    input  logic [core_pkg::xlen-1:0] ls_addr,
    input  logic [core_pkg::xlen-1:0] ls_wdata,
    output logic                      ls_busy,
    output logic                      ls_done,
    output logic [core_pkg::xlen-1:0] ls_rdata,

    // arbiter side
    output logic                      d_start,
    output logic                      d_write,
    output logic [core_pkg::xlen-1:0] d_addr,
    output logic [core_pkg::xlen-1:0] d_wdata,
    input  logic                      d_ready,
    input  logic [core_pkg::xlen-1:0] d_rdata,
    input  logic                      d_rdata_valid
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_request,
        s_wait_done
    } state_t;

    state_t          state;
    logic            write_q;
    logic [xlen-1:0] addr_q;
    logic [xlen-1:0] wdata_q;

    assign ls_busy = (state != s_idle);
    assign d_start = (state == s_request);
    assign d_write = write_q;
    assign d_addr  = addr_q;
    assign d_wdata = wdata_q;

    // completion straight from the arbiter pulse
    assign ls_done  = (state == s_wait_done) && d_rdata_valid;
    assign ls_rdata = d_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:      if (ls_req) state <= s_request;
                s_request:   if (d_ready) state <= s_wait_done;
                s_wait_done: if (d_rdata_valid) state <= s_idle;
                default:     state <= s_idle;
            endcase
        end
    end

    // request capture
    always_ff @(posedge clk) begin
        if (ls_req && state == s_idle) begin
            write_q <= ls_write;
            addr_q  <= ls_addr;
            wdata_q <= ls_wdata;
        end
    end

    // only one access at a time from outside
    single_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        ls_req |-> !ls_busy
    ) else $error("ls_req while the port is busy");

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int mem_latency = core_pkg::def_mem_latency
) (
    input  logic                      clk,
    input  logic                      rst_n,

    // fetch requester
    input  logic                      f_start,
    output logic                      f_ready,
    input  logic [core_pkg::xlen-1:0] f_addr,
    output logic [core_pkg::xlen-1:0] f_rdata,
    output logic                      f_rdata_valid,

    // data requester
    input  logic                      d_start,
    output logic                      d_ready,
    input  logic                      d_write,
    input  logic [core_pkg::xlen-1:0] d_addr,
    input  logic [core_pkg::xlen-1:0] d_wdata,
    output logic [core_pkg::xlen-1:0] d_rdata,
    output logic                      d_rdata_valid,

    // memory side
    output logic                      mem_start,
    output logic                      mem_write,
    output logic [core_pkg::xlen-1:0] mem_addr,
    output logic [core_pkg::xlen-1:0] mem_wdata,
    input  logic                      mem_ready,
    input  logic [core_pkg::xlen-1:0] mem_rdata,
    input  logic                      mem_rdata_valid
);

    logic                   accept;
    // one slot per latency cycle, oldest at the top
    logic [mem_latency-1:0] own_vld;
    logic [mem_latency-1:0] own_data;
    logic                   done_vld;
    logic                   done_data;

    // data side wins whenever it asks
    assign mem_start = d_start || f_start;
    assign mem_write = d_start && d_write;
    assign mem_addr  = d_start ? d_addr : f_addr;
    assign mem_wdata = d_wdata;

    assign d_ready = mem_ready;
    assign f_ready = mem_ready && !d_start;
    assign accept  = mem_start && mem_ready;

    assign done_vld  = own_vld[mem_latency-1];
    assign done_data = own_data[mem_latency-1];

    // response data is shared, only the valid is steered
    assign d_rdata       = mem_rdata;
    assign f_rdata       = mem_rdata;
    assign d_rdata_valid = mem_rdata_valid && done_vld && done_data;
    assign f_rdata_valid = mem_rdata_valid && done_vld && !done_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            own_vld <= '0;
        end else begin
            own_vld[0] <= accept;
            for (int i = 1; i < mem_latency; i++) begin
                own_vld[i] <= own_vld[i-1];
            end
        end
    end

    // owner bit, meaningful only where own_vld is set
    always_ff @(posedge clk) begin
        own_data[0] <= d_start;
        for (int i = 1; i < mem_latency; i++) begin
            own_data[i] <= own_data[i-1];
        end
    end

    // memory latency and owner record must line up
    owner_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_rdata_valid |-> done_vld
    ) else $error("memory completion without a recorded owner");

endmodule

/* design/unified_memory.sv */
`timescale 1ns/1ps

module unified_memory #(
    parameter int mem_latency = core_pkg::def_mem_latency,
    parameter int mem_addr_w  = core_pkg::def_mem_addr_w
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      mem_start,
    input  logic                      mem_write,
    input  logic [core_pkg::xlen-1:0] mem_addr,
    input  logic [core_pkg::xlen-1:0] mem_wdata,

    output logic                      mem_ready,
    output logic [core_pkg::xlen-1:0] mem_rdata,
    output logic                      mem_rdata_valid
);
    import core_pkg::*;

    localparam int cnt_w = $clog2(mem_latency + 1);

    logic [xlen-1:0]       mem_array [2**mem_addr_w];
    logic [mem_addr_w-1:0] word_idx;
    logic [xlen-1:0]       rdata_q;
    logic                  pending_q;
    logic [cnt_w-1:0]      cnt_q;
    logic                  accept;

    // word index, byte offset dropped
    assign word_idx = mem_addr[mem_addr_w+1:2];

    assign mem_rdata_valid = pending_q && (cnt_q == '0);
    // ready again in the valid cycle so accesses can go back to back
    assign mem_ready       = !pending_q || mem_rdata_valid;
    assign accept          = mem_start && mem_ready;
    assign mem_rdata       = rdata_q;

    // latency counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            cnt_q     <= '0;
        end else if (accept) begin
            pending_q <= 1'b1;
            cnt_q     <= cnt_w'(mem_latency - 1);
        end else if (mem_rdata_valid) begin
            pending_q <= 1'b0;
        end else if (pending_q) begin
            cnt_q <= cnt_q - cnt_w'(1);
        end
    end

    // array access on the accepting edge
    // a write returns the old word, which nobody looks at
    always_ff @(posedge clk) begin
        if (accept) begin
            if (mem_write) begin
                mem_array[word_idx] <= mem_wdata;
            end
            rdata_q <= mem_array[word_idx];
        end
    end

    // every accepted access completes exactly mem_latency cycles later
    latency_contract: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |-> ##mem_latency mem_rdata_valid
    ) else $error("memory completion not at the fixed latency");

endmodule

/* flist.f */
design/core_pkg.sv
design/unified_memory.sv
design/mem_arbiter.sv
design/load_store_port.sv
design/fetch_stage.sv
design/core_front.sv
tb/tb_checker.sv
tb/tb_top.sv

/* tb/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
    parameter int mem_addr_w = core_pkg::def_mem_addr_w
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           if_valid,
    input  logic [core_pkg::xlen-1:0]      if_pc,
    input  logic [core_pkg::xlen-1:0]      if_inst,
    input  logic [core_pkg::inst_id_w-1:0] if_inst_id,
    input  logic                           if_stall,
    input  logic                           branch_hazard,
    input  logic [core_pkg::xlen-1:0]      branch_target,
    input  logic                           ls_req,
    input  logic                           ls_write,
    input  logic [core_pkg::xlen-1:0]      ls_addr,
    input  logic [core_pkg::xlen-1:0]      ls_wdata,
    input  logic                           ls_busy,
    input  logic                           ls_done,
    input  logic [core_pkg::xlen-1:0]      ls_rdata,
    input  int                             row_idx,
    input  logic                           row_end,
    output int                             error_count,
    output int                             check_count
);
    import core_pkg::*;

    // word contents written by completed stores
    logic [xlen-1:0]      shadow [int];
    logic [xlen-1:0]      exp_pc;
    logic [inst_id_w-1:0] exp_id;
    logic                 was_stalled;
    logic [xlen-1:0]      held_pc;
    logic [xlen-1:0]      held_inst;
    logic [inst_id_w-1:0] held_id;
    // the one data access currently open
    logic                 ls_open;
    logic                 ls_open_write;
    logic [xlen-1:0]      ls_open_addr;
    logic [xlen-1:0]      ls_open_wdata;
    bit                   after_reset;
    int                   reset_cycles = 0;
    int                   deliveries = 0;
    int                   base_deliveries = 0;
    int                   base_errors = 0;

    function automatic int word_of(input logic [xlen-1:0] addr);
        return int'(addr[mem_addr_w+1:2]);
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // inputs move 1 ns after the rising edge, so the falling edge sees settled values
    always @(negedge clk) begin
        if (!rst_n) begin
            if (reset_cycles == 0) begin
                error_count = 0;
                check_count = 0;
            end else begin
                compare("if_valid", 64'(1'b0), 64'(if_valid));
                compare("ls_busy", 64'(1'b0), 64'(ls_busy));
                compare("ls_done", 64'(1'b0), 64'(ls_done));
            end
            reset_cycles++;
            exp_pc      = reset_pc;
            exp_id      = '0;
            was_stalled = 1'b0;
            ls_open     = 1'b0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                compare("if_valid", 64'(1'b0), 64'(if_valid));
                compare("ls_busy", 64'(1'b0), 64'(ls_busy));
                compare("ls_done", 64'(1'b0), 64'(ls_done));
                after_reset = 1'b0;
            end

            if (branch_hazard) begin
                compare("if_valid", 64'(1'b0), 64'(if_valid));
                exp_pc      = branch_target;
                exp_id      = exp_id + inst_id_w'(1);
                was_stalled = 1'b0;
            end else begin
                if (was_stalled) begin
                    compare("if_valid", 64'(1'b1), 64'(if_valid));
                    compare("if_pc", 64'(held_pc), 64'(if_pc));
                    compare("if_inst", 64'(held_inst), 64'(if_inst));
                    compare("if_inst_id", 64'(held_id), 64'(if_inst_id));
                end else if (if_valid && shadow.exists(word_of(if_pc))) begin
                    // skip a word with a store still in flight
                    if (!(ls_open && ls_open_write &&
                          word_of(ls_open_addr) == word_of(if_pc))) begin
                        compare("if_inst", 64'(shadow[word_of(if_pc)]), 64'(if_inst));
                    end
                end
                if (if_valid) begin
                    compare("if_pc", 64'(exp_pc), 64'(if_pc));
                    compare("if_inst_id", 64'(exp_id), 64'(if_inst_id));
                    if (!if_stall) begin
                        exp_pc = exp_pc + 32'd4;
                        exp_id = exp_id + inst_id_w'(1);
                        deliveries++;
                    end
                end
                was_stalled = if_valid && if_stall;
                held_pc     = if_pc;
                held_inst   = if_inst;
                held_id     = if_inst_id;
            end

            // busy from the cycle after the strobe through ls_done
            compare("ls_busy", 64'(ls_open), 64'(ls_busy));

            if (ls_done) begin
                if (!ls_open) begin
                    error_count++;
                    $display("ls_done pulsed at %0t with no data request open", $time);
                end else if (ls_open_write) begin
                    shadow[word_of(ls_open_addr)] = ls_open_wdata;
                end else if (shadow.exists(word_of(ls_open_addr))) begin
                    compare("ls_rdata", 64'(shadow[word_of(ls_open_addr)]), 64'(ls_rdata));
                end
                ls_open = 1'b0;
            end
            if (ls_req) begin
                ls_open       = 1'b1;
                ls_open_write = ls_write;
                ls_open_addr  = ls_addr;
                ls_open_wdata = ls_wdata;
            end

            if (row_end) begin
                $display("row %0d done: %0d deliveries, %0d errors", row_idx,
                         deliveries - base_deliveries, error_count - base_errors);
                base_deliveries = deliveries;
                base_errors     = error_count;
            end
        end
    end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    import core_pkg::*;

    localparam int mem_latency = def_mem_latency;
    localparam int mem_addr_w  = def_mem_addr_w;
    // cycles allowed between a data request and its ls_done
    localparam int done_limit  = 64;

    typedef struct packed {
        logic            ls_req;
        logic            ls_write;
        logic [xlen-1:0] ls_addr;
        logic [xlen-1:0] ls_wdata;
        logic            if_stall;
        logic            branch_hazard;
        logic [xlen-1:0] branch_target;
        logic [7:0]      hold;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    logic                 if_valid;
    logic [xlen-1:0]      if_pc;
    logic [xlen-1:0]      if_inst;
    logic [inst_id_w-1:0] if_inst_id;
    logic                 if_stall;
    logic                 branch_hazard;
    logic [xlen-1:0]      branch_target;
    logic                 ls_req;
    logic                 ls_write;
    logic [xlen-1:0]      ls_addr;
    logic [xlen-1:0]      ls_wdata;
    logic                 ls_busy;
    logic                 ls_done;
    logic [xlen-1:0]      ls_rdata;

    row_t        stim [$];
    bit          table_ready = 1'b0;
    logic [31:0] lfsr_state;
    int          row_idx;
    logic        row_end;
    int          req_count = 0;
    int          done_count = 0;
    int          stim_errors = 0;
    int          chk_errors;
    int          chk_checks;

    always #2 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && ls_done) done_count++;
    end

    core_front #(
        .mem_latency (mem_latency),
        .mem_addr_w  (mem_addr_w)
    ) DUT (
        .clk (clk), .rst_n (rst_n),
        .if_valid (if_valid), .if_pc (if_pc), .if_inst (if_inst), .if_inst_id (if_inst_id),
        .if_stall (if_stall), .branch_hazard (branch_hazard), .branch_target (branch_target),
        .ls_req (ls_req), .ls_write (ls_write), .ls_addr (ls_addr), .ls_wdata (ls_wdata),
        .ls_busy (ls_busy), .ls_done (ls_done), .ls_rdata (ls_rdata)
    );

    tb_checker #(.mem_addr_w (mem_addr_w)) u_check (
        .clk (clk), .rst_n (rst_n),
        .if_valid (if_valid), .if_pc (if_pc), .if_inst (if_inst), .if_inst_id (if_inst_id),
        .if_stall (if_stall), .branch_hazard (branch_hazard), .branch_target (branch_target),
        .ls_req (ls_req), .ls_write (ls_write), .ls_addr (ls_addr), .ls_wdata (ls_wdata),
        .ls_busy (ls_busy), .ls_done (ls_done), .ls_rdata (ls_rdata),
        .row_idx (row_idx), .row_end (row_end),
        .error_count (chk_errors), .check_count (chk_checks)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic add_row(input logic req, input logic write, input logic [xlen-1:0] addr,
                           input logic [xlen-1:0] wdata, input logic stall,
                           input logic hazard, input logic [xlen-1:0] target, input int hold);
        row_t r;
        r = {req, write, addr, wdata, stall, hazard, target, 8'(hold)};
        stim.push_back(r);
    endtask

    task automatic build_table();
        // req  wr    addr           wdata mask     stall hazard target    hold
        // hold 0 on a stall row picks a random length
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000, 6);
        add_row(1'b1, 1'b1, 32'h0000_0200, 32'h1111_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b1, 1'b1, 32'h0000_0204, 32'h2222_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b1, 1'b1, 32'h0000_0208, 32'h3333_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b1, 1'b1, 32'h0000_020c, 32'h4444_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b1, 1'b1, 32'h0000_0100, 32'h5555_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b1, 1'b1, 32'h0000_0104, 32'h6666_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b1, 1'b0, 32'h0000_0204, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000, 0);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000, 5);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0200, 1);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000, 3);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0204, 2);
        add_row(1'b1, 1'b0, 32'h0000_0100, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b1, 1'b1, 32'h0000_0300, 32'h7777_0000, 1'b1, 1'b0, 32'h0000_0000, 0);
        // redirects three cycles apart, one of them lands on an outstanding fetch
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0300, 2);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0204, 2);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0200, 1);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000, 0);
        add_row(1'b1, 1'b1, 32'h0000_0208, 32'h8888_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0208, 4);
        add_row(1'b1, 1'b0, 32'h0000_0208, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_00f0, 60);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000, 0);
        add_row(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000, 20);
        add_row(1'b1, 1'b0, 32'h0000_0300, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000, 1);
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        while (done_count < req_count && waited < done_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (done_count < req_count) begin
            $display("ls_done never followed the data request of row %0d", row_idx);
            stim_errors++;
            req_count = done_count;
        end
    endtask

    task automatic run_row(input int r);
        row_t        row;
        logic [31:0] rnd;
        int          cycles;
        row    = stim[r];
        cycles = int'(row.hold);
        if (row.if_stall && cycles == 0) begin
            next_bits(3, rnd);
            cycles = int'(rnd) + 1;
        end
        if (cycles == 0) cycles = 1;
        @(posedge clk);
        #1;
        row_end       = 1'b0;
        row_idx       = r;
        ls_req        = row.ls_req;
        ls_write      = row.ls_write;
        ls_addr       = row.ls_addr;
        ls_wdata      = row.ls_wdata;
        if (row.ls_req && row.ls_write) begin
            next_bits(32, rnd);
            ls_wdata = row.ls_wdata ^ rnd;
        end
        if_stall      = row.if_stall;
        branch_hazard = row.branch_hazard;
        branch_target = row.branch_target;
        if (row.ls_req) req_count++;
        // request and redirect are single-cycle strobes
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            ls_req        = 1'b0;
            branch_hazard = 1'b0;
        end
        if_stall = 1'b0;
        wait_for_done();
        row_end = 1'b1;
    endtask

    initial begin
        int limit_cycles;
        wait (table_ready);
        limit_cycles = 150;
        foreach (stim[i]) begin
            limit_cycles += (stim[i].hold == 8'd0) ? 8 : int'(stim[i].hold);
        end
        #(limit_cycles * 4 + 1000);
        $display("timeout: the run did not finish in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        ls_req        = 1'b0;
        ls_write      = 1'b0;
        ls_addr       = '0;
        ls_wdata      = '0;
        if_stall      = 1'b0;
        branch_hazard = 1'b0;
        branch_target = '0;
        row_idx       = 0;
        row_end       = 1'b0;
        lfsr_state    = 32'h27ec_5680;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (6) @(posedge clk);
        for (int r = 0; r < stim.size(); r++) begin
            run_row(r);
        end
        @(posedge clk);
        #1;
        row_end = 1'b0;
        repeat (10) @(posedge clk);
        $display("checks %0d, checker errors %0d, stimulus errors %0d",
                 chk_checks, chk_errors, stim_errors);
        if (chk_errors + stim_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
